// ==== include/memSystem_params.svh ====
/*
 * fixed widths of the cache and the memory, shared by every block
 * TAG_W + INDEX_W + OFFSET_W must add up to ADDR_W
 */
`ifndef MEMSYSTEM_PARAMS_SVH
`define MEMSYSTEM_PARAMS_SVH

// byte address and word width
`define ADDR_W      16
`define DATA_W      16

// address split as seen by the cache
`define TAG_W       5
`define INDEX_W     8
// byte offset inside a line, bit 0 is always zero
`define OFFSET_W    3

`define LINE_WORDS  4

// cycles from an accepted read command to its data
`define MEM_LATENCY 3

`endif

// ==== logic/memSysPkg.sv ====
/*
 * types shared by the cache and its controller
 * cacheAddrT relies on tag + index + offset filling the whole byte address
 */
`include "memSystem_params.svh"

package memSysPkg;

   // cache view of a byte address, msb first
   typedef struct packed {
      logic [`TAG_W-1:0]    tag;
      logic [`INDEX_W-1:0]  index;
      logic [`OFFSET_W-1:0] offset;
   } addrFieldsT;

   typedef union packed {
      logic [`ADDR_W-1:0] flat;    // as the memory sees it
      addrFieldsT         split;   // as the ways see it
   } cacheAddrT;

   typedef enum logic [2:0] {
      idle,
      compare,
      writeBack,   // entered only for a dirty victim
      fill,
      fillWait,
      finish
   } ctrlStateT;

endpackage

// ==== logic/cacheWay.sv ====
/*
 * one way of the cache: tag, valid, dirty and LINE_WORDS data words per set
 * lookup is combinational; writes and line updates land on the clock edge
 */
`timescale 1ns/1ps
`include "memSystem_params.svh"

module cacheWay (
   input  logic                 clk,
   input  logic                 rstN,
   input  logic [`INDEX_W-1:0]  index,
   input  logic [`TAG_W-1:0]    tag,
   input  logic [`OFFSET_W-2:0] wordSel,
   input  logic [`DATA_W-1:0]   wrData,
   input  logic                 wrEn,
   input  logic                 lineSet,   // new tag, valid set, dirty from dirtyIn
   input  logic                 dirtyIn,
   output logic                 hit,
   output logic                 valid,
   output logic                 dirty,
   output logic [`TAG_W-1:0]    storedTag,
   output logic [`DATA_W-1:0]   rdData
);
   import memSysPkg::*;

   localparam int SETS = 1 << `INDEX_W;

   logic [`TAG_W-1:0]  tagMem  [0:SETS-1];
   logic [`DATA_W-1:0] dataMem [0:SETS-1][0:`LINE_WORDS-1];
   logic [SETS-1:0]    validBits;
   logic [SETS-1:0]    dirtyBits;

   cacheAddrT                probe;   // the addressed slot, rebuilt as a byte address
   logic [`OFFSET_W-2:0]     wordIdx;

   assign probe.flat = {tag, index, wordSel, 1'b0};
   assign wordIdx    = probe.split.offset[`OFFSET_W-1:1];

   assign valid     = validBits[probe.split.index];
   assign dirty     = dirtyBits[probe.split.index];
   assign storedTag = tagMem[probe.split.index];
   assign hit       = valid && (storedTag == probe.split.tag);
   assign rdData    = dataMem[probe.split.index][wordIdx];

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         validBits <= '0;
         dirtyBits <= '0;
      end else if (lineSet) begin
         validBits[probe.split.index] <= 1'b1;
         dirtyBits[probe.split.index] <= dirtyIn;
      end else if (wrEn) begin
         dirtyBits[probe.split.index] <= 1'b1;   // plain write hit
      end
   end

   always_ff @(posedge clk) begin
      if (lineSet) begin
         tagMem[probe.split.index] <= probe.split.tag;
      end
      if (wrEn) begin
         dataMem[probe.split.index][wordIdx] <= wrData;
      end
   end

   // the controller only writes into a line that it has already claimed
   wrIntoValidLine: assert property (
      @(posedge clk) disable iff (!rstN)
      (wrEn && !lineSet) |-> valid
   ) else $error("cacheWay: word write into an invalid line");

endmodule

// ==== logic/mainMemory.sv ====
/*
 * single-port word memory, 2^15 words, cleared at start of simulation
 * a read returns MEM_LATENCY cycles after its command; writes finish on transfer
 * only one read may be outstanding, memCmdReady drops until its data returns
 */
`timescale 1ns/1ps
`include "memSystem_params.svh"

module mainMemory (
   input  logic                clk,
   input  logic                rstN,
   input  logic                memCmdValid,
   output logic                memCmdReady,
   input  logic                memWrite,
   input  logic [`ADDR_W-1:0]  memAddr,   // byte address
   input  logic [`DATA_W-1:0]  memWrData,
   output logic                memRdValid,
   output logic [`DATA_W-1:0]  memRdData
);

   localparam int WORDS = 1 << (`ADDR_W - 1);

   logic [`DATA_W-1:0]      mem [0:WORDS-1];
   logic [`MEM_LATENCY-1:0] readPipe;   // one-hot countdown of the pending read
   logic [`ADDR_W-2:0]      wordAddr;
   logic                    cmdFire;

   initial begin
      for (int i = 0; i < WORDS; i++) begin
         mem[i] = '0;
      end
   end

   assign wordAddr    = memAddr[`ADDR_W-1:1];
   assign memCmdReady = ~|readPipe;
   assign cmdFire     = memCmdValid && memCmdReady;
   assign memRdValid  = readPipe[0];

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         readPipe <= '0;
      end else if (cmdFire && !memWrite) begin
         readPipe <= {1'b1, {(`MEM_LATENCY-1){1'b0}}};
      end else begin
         readPipe <= readPipe >> 1;
      end
   end

   // read word is captured at the command, nothing can write it before delivery
   always_ff @(posedge clk) begin
      if (cmdFire) begin
         if (memWrite) begin
            mem[wordAddr] <= memWrData;
         end else begin
            memRdData <= mem[wordAddr];
         end
      end
   end

   // a stalled command must keep its address until the memory takes it
   cmdAddrHeld: assert property (
      @(posedge clk) disable iff (!rstN)
      (memCmdValid && !memCmdReady) |=> $stable(memAddr)
   ) else $error("mainMemory: address changed while command stalled");

endmodule

// ==== logic/cacheController.sv ====
/*
 * miss and hit FSM for the two-way write-back cache, one request at a time
 * hits answer 2 cycles after acceptance; misses write back a dirty victim, then fill
 * responses have no ready, the requester must take respValid when it comes
 */
`timescale 1ns/1ps
`include "memSystem_params.svh"

module cacheController (
   input  logic                 clk,
   input  logic                 rstN,
   // requester side
   input  logic                 reqValid,
   output logic                 reqReady,
   input  logic                 reqRead,
   input  logic [`ADDR_W-1:0]   reqAddr,
   input  logic [`DATA_W-1:0]   reqWrData,
   output logic                 respValid,
   output logic [`DATA_W-1:0]   respRdData,
   output logic                 respHit,
   // shared way controls
   output logic [`INDEX_W-1:0]  index,
   output logic [`TAG_W-1:0]    tag,
   output logic [`OFFSET_W-2:0] wordSel,
   output logic [`DATA_W-1:0]   wrData,
   output logic                 dirtyIn,
   // per way
   output logic                 wrEn0,
   output logic                 wrEn1,
   output logic                 lineSet0,
   output logic                 lineSet1,
   input  logic                 hit0,
   input  logic                 hit1,
   input  logic                 valid0,
   input  logic                 valid1,
   input  logic                 dirty0,
   input  logic                 dirty1,
   input  logic [`TAG_W-1:0]    storedTag0,
   input  logic [`TAG_W-1:0]    storedTag1,
   input  logic [`DATA_W-1:0]   rdData0,
   input  logic [`DATA_W-1:0]   rdData1,
   // memory side
   output logic                 memCmdValid,
   input  logic                 memCmdReady,
   output logic                 memWrite,
   output logic [`ADDR_W-1:0]   memAddr,
   output logic [`DATA_W-1:0]   memWrData,
   input  logic                 memRdValid,
   input  logic [`DATA_W-1:0]   memRdData
);
   import memSysPkg::*;

   localparam logic [`OFFSET_W-2:0] LAST_WORD = '1;   // LINE_WORDS - 1

   ctrlStateT            state, nextState;
   cacheAddrT            reqAddrQ;
   cacheAddrT            cmdAddr;
   logic                 reqReadQ;
   logic [`DATA_W-1:0]   reqWrDataQ;
   logic                 victimBit;   // flips on every accepted request
   logic                 victimWay;   // way being replaced, held for the whole miss
   logic [`TAG_W-1:0]    victimTag;
   logic [`OFFSET_W-2:0] wordCnt;
   logic [`OFFSET_W-2:0] reqWord;
   logic                 hitAny;
   logic                 pickWay;
   logic                 pickDirty;
   logic [`TAG_W-1:0]    pickTag;
   logic [`DATA_W-1:0]   hitData;
   logic [`DATA_W-1:0]   victimData;

   assign reqReady   = (state == idle);
   assign index      = reqAddrQ.split.index;
   assign tag        = reqAddrQ.split.tag;
   assign reqWord    = reqAddrQ.split.offset[`OFFSET_W-1:1];
   assign hitAny     = hit0 | hit1;
   assign hitData    = hit1 ? rdData1 : rdData0;
   assign victimData = victimWay ? rdData1 : rdData0;
   assign memWrData  = victimData;   // write-back reads the victim word by word
   assign memAddr    = cmdAddr.flat;

   // an invalid way goes first, otherwise the victim bit decides
   always_comb begin
      if (!valid0) begin
         pickWay = 1'b0;
      end else if (!valid1) begin
         pickWay = 1'b1;
      end else begin
         pickWay = victimBit;
      end
   end

   assign pickDirty = pickWay ? dirty1 : dirty0;
   assign pickTag   = pickWay ? storedTag1 : storedTag0;

   always_comb begin
      nextState            = state;
      wordSel              = reqWord;
      wrData               = reqWrDataQ;
      dirtyIn              = 1'b0;
      wrEn0                = 1'b0;
      wrEn1                = 1'b0;
      lineSet0             = 1'b0;
      lineSet1             = 1'b0;
      memCmdValid          = 1'b0;
      memWrite             = 1'b0;
      cmdAddr.split.tag    = reqAddrQ.split.tag;
      cmdAddr.split.index  = reqAddrQ.split.index;
      cmdAddr.split.offset = {wordCnt, 1'b0};
      case (state)
         idle: begin
            if (reqValid) nextState = compare;
         end
         compare: begin
            if (hitAny) begin
               wrEn0     = !reqReadQ && hit0;
               wrEn1     = !reqReadQ && hit1;
               nextState = idle;
            end else if (pickDirty) begin
               nextState = writeBack;
            end else begin
               nextState = fill;
            end
         end
         writeBack: begin
            wordSel           = wordCnt;
            memCmdValid       = 1'b1;
            memWrite          = 1'b1;
            cmdAddr.split.tag = victimTag;   // old line goes back to its own address
            if (memCmdReady && wordCnt == LAST_WORD) nextState = fill;
         end
         fill: begin
            memCmdValid = 1'b1;
            if (memCmdReady) nextState = fillWait;
         end
         fillWait: begin
            wordSel = wordCnt;
            wrData  = memRdData;
            if (memRdValid) begin
               // fill words claim the line clean, so the write never hits an invalid line
               wrEn0     = !victimWay;
               wrEn1     = victimWay;
               lineSet0  = !victimWay;
               lineSet1  = victimWay;
               nextState = (wordCnt == LAST_WORD) ? finish : fill;
            end
         end
         finish: begin
            // merge the write word and mark dirty in one go
            wrEn0     = !reqReadQ && !victimWay;
            wrEn1     = !reqReadQ && victimWay;
            lineSet0  = !victimWay;
            lineSet1  = victimWay;
            dirtyIn   = !reqReadQ;
            nextState = idle;
         end
         default: nextState = idle;
      endcase
   end

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         state     <= idle;
         victimBit <= 1'b0;
         wordCnt   <= '0;
         respValid <= 1'b0;
      end else begin
         state     <= nextState;
         respValid <= (state == compare && hitAny) || state == finish;
         if (reqValid && reqReady) victimBit <= ~victimBit;
         if (state == compare) begin
            wordCnt <= '0;
         end else if ((state == writeBack && memCmdReady) ||
                      (state == fillWait && memRdValid)) begin
            wordCnt <= wordCnt + 1'b1;   // wraps to 0 between write-back and fill
         end
      end
   end

   always_ff @(posedge clk) begin
      if (reqValid && reqReady) begin
         reqAddrQ   <= reqAddr;
         reqReadQ   <= reqRead;
         reqWrDataQ <= reqWrData;
      end
      if (state == compare) begin
         victimWay  <= pickWay;
         victimTag  <= pickTag;
         respHit    <= hitAny;
         respRdData <= reqReadQ ? hitData : reqWrDataQ;
      end else if (state == finish) begin
         respHit    <= 1'b0;
         respRdData <= reqReadQ ? victimData : reqWrDataQ;
      end
   end

   // a tag lives in at most one way of a set
   oneWayHit: assert property (
      @(posedge clk) disable iff (!rstN)
      (state == compare) |-> !(hit0 && hit1)
   ) else $error("cacheController: both ways hit");

   respPulse: assert property (
      @(posedge clk) disable iff (!rstN)
      respValid |=> !respValid
   ) else $error("cacheController: respValid longer than one cycle");

endmodule

// ==== logic/memSystem.sv ====
/*
 * two-way write-back cache with write-allocate in front of a fixed-latency memory
 * requests use valid/ready, responses are a one-cycle pulse with no back-pressure
 */
`timescale 1ns/1ps
`include "memSystem_params.svh"

module memSystem (
   input  logic                clk,
   input  logic                rstN,
   input  logic                reqValid,
   output logic                reqReady,
   input  logic                reqRead,     // 1 read, 0 write
   input  logic [`ADDR_W-1:0]  reqAddr,
   input  logic [`DATA_W-1:0]  reqWrData,
   output logic                respValid,
   output logic [`DATA_W-1:0]  respRdData,
   output logic                respHit
);
   import memSysPkg::*;

   // way side
   logic [`INDEX_W-1:0]  index;
   logic [`TAG_W-1:0]    tag;
   logic [`OFFSET_W-2:0] wordSel;
   logic [`DATA_W-1:0]   wrData;
   logic                 dirtyIn;
   logic                 wrEn0, wrEn1;
   logic                 lineSet0, lineSet1;
   logic                 hit0, hit1;
   logic                 valid0, valid1;
   logic                 dirty0, dirty1;
   logic [`TAG_W-1:0]    storedTag0, storedTag1;
   logic [`DATA_W-1:0]   rdData0, rdData1;

   // memory side
   logic                 memCmdValid, memCmdReady, memWrite;
   cacheAddrT            memAddr;
   logic [`DATA_W-1:0]   memWrData, memRdData;
   logic                 memRdValid;

   cacheWay way0 (.clk, .rstN, .index, .tag, .wordSel, .wrData, .wrEn(wrEn0),
                  .lineSet(lineSet0), .dirtyIn, .hit(hit0), .valid(valid0),
                  .dirty(dirty0), .storedTag(storedTag0), .rdData(rdData0));

   cacheWay way1 (.clk, .rstN, .index, .tag, .wordSel, .wrData, .wrEn(wrEn1),
                  .lineSet(lineSet1), .dirtyIn, .hit(hit1), .valid(valid1),
                  .dirty(dirty1), .storedTag(storedTag1), .rdData(rdData1));

   cacheController ctrl (
      .clk, .rstN, .reqValid, .reqReady, .reqRead, .reqAddr, .reqWrData,
      .respValid, .respRdData, .respHit,
      .index, .tag, .wordSel, .wrData, .dirtyIn, .wrEn0, .wrEn1, .lineSet0, .lineSet1,
      .hit0, .hit1, .valid0, .valid1, .dirty0, .dirty1, .storedTag0, .storedTag1,
      .rdData0, .rdData1,
      .memCmdValid, .memCmdReady, .memWrite, .memAddr, .memWrData,
      .memRdValid, .memRdData
   );

   mainMemory mem (
      .clk, .rstN, .memCmdValid, .memCmdReady, .memWrite,
      .memAddr(memAddr.flat), .memWrData, .memRdValid, .memRdData
   );

endmodule

// ==== verif/memSystemTb.sv ====
/*
 * a directed table runs first and 200 random requests follow
 * outputs are sampled on the falling edge
 * expected hits come from a tag model with one victim bit shared by all sets
 * only word-aligned addresses are used so bit 0 stays clear
 */
`timescale 1ns/1ps
`include "memSystem_params.svh"

module memSystemTb;

   localparam int TIMEOUT = 100;   // cycles allowed for any single wait
   localparam int SETS    = 1 << `INDEX_W;
   localparam int WORDS   = 1 << (`ADDR_W - 1);
   localparam int N_RAND  = 200;

   typedef struct packed {
      int                 testId;
      logic               isRead;
      logic [`ADDR_W-1:0] addr;
      logic [`DATA_W-1:0] data;     // write data or the expected read data
      logic               expHit;
   } stepT;

   logic               clk;
   logic               rstN;
   logic               reqValid;
   logic               reqReady;
   logic               reqRead;
   logic [`ADDR_W-1:0] reqAddr;
   logic [`DATA_W-1:0] reqWrData;
   logic               respValid;
   logic [`DATA_W-1:0] respRdData;
   logic               respHit;

   logic [`DATA_W-1:0] refMem [0:WORDS-1];   // what memory plus cache must hold
   logic               refValid [0:1][0:SETS-1];
   logic [`TAG_W-1:0]  refTag [0:1][0:SETS-1];
   logic               refVictim;
   logic [31:0]        rngState;
   stepT               steps[$];
   int                 errors;
   int                 testErrors;
   int                 testsRun;
   int                 testsPassed;
   logic               timedOut;
   string              testNames [1:6] = '{"cold read", "write then read", "two tags per set",
                                           "dirty eviction", "response timing", "random"};

   memSystem DUT (
      .clk, .rstN, .reqValid, .reqReady, .reqRead, .reqAddr, .reqWrData,
      .respValid, .respRdData, .respHit
   );

   initial clk = 1'b0;
   always #20 clk = ~clk;

   function automatic logic [`ADDR_W-1:0] makeAddr(input logic [`TAG_W-1:0] t,
         input logic [`INDEX_W-1:0] i, input logic [`OFFSET_W-2:0] w);
      return {t, i, w, 1'b0};
   endfunction

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // tag model picks an invalid way first and otherwise follows the victim bit
   // the victim bit flips before the lookup
   function automatic logic modelAccess(input logic [`ADDR_W-1:0] addr);
      logic [`TAG_W-1:0]   t;
      logic [`INDEX_W-1:0] i;
      logic                w;
      t = addr[`ADDR_W-1 -: `TAG_W];
      i = addr[`OFFSET_W +: `INDEX_W];
      refVictim = ~refVictim;
      if ((refValid[0][i] && refTag[0][i] == t) || (refValid[1][i] && refTag[1][i] == t)) begin
         return 1'b1;
      end
      if (!refValid[0][i]) begin
         w = 1'b0;
      end else if (!refValid[1][i]) begin
         w = 1'b1;
      end else begin
         w = refVictim;
      end
      refValid[w][i] = 1'b1;
      refTag[w][i]   = t;
      return 1'b0;
   endfunction

   task automatic addStep(input int id, input logic rd, input logic [`TAG_W-1:0] t,
                          input logic [`INDEX_W-1:0] i, input logic [`OFFSET_W-2:0] w,
                          input logic [`DATA_W-1:0] d, input logic h);
      stepT s;
      s.testId = id;
      s.isRead = rd;
      s.addr   = makeAddr(t, i, w);
      s.data   = d;
      s.expHit = h;
      steps.push_back(s);
   endtask

   task automatic reportError(input string msg);
      $display("** Error at %0d ns: %s", $time, msg);
      errors++;
      testErrors++;
   endtask

   task automatic finishTest(input int id);
      testsRun++;
      if (testErrors == 0) begin
         testsPassed++;
         $display("test %0d (%s): ok", id, testNames[id]);
      end else begin
         $display("test %0d (%s): %0d errors", id, testNames[id], testErrors);
      end
      testErrors = 0;
   endtask

   // starts and ends on a falling edge
   // latency counts falling edges after the drive
   task automatic doRequest(input logic isRead, input logic [`ADDR_W-1:0] addr,
                            input logic [`DATA_W-1:0] data, output logic hit,
                            output logic [`DATA_W-1:0] rdData, output int latency);
      int waitCnt;
      waitCnt = 0;
      hit     = 1'b0;
      rdData  = '0;
      latency = 0;
      while (!reqReady && waitCnt < TIMEOUT) begin
         @(negedge clk);
         waitCnt++;
      end
      if (!reqReady) begin
         $display("timeout: reqReady stayed low for %0d cycles", TIMEOUT);
         timedOut = 1'b1;
         return;
      end
      reqValid  = 1'b1;
      reqRead   = isRead;
      reqAddr   = addr;
      reqWrData = data;
      @(negedge clk);
      reqValid = 1'b0;   // taken on the edge just passed
      latency  = 1;
      while (!respValid && latency < TIMEOUT) begin
         if (reqReady) begin
            reportError($sformatf("reqReady high before the response to %h", addr));
         end
         @(negedge clk);
         latency++;
      end
      if (!respValid) begin
         $display("timeout: no response to the request at address %h", addr);
         timedOut = 1'b1;
         return;
      end
      hit    = respHit;
      rdData = respRdData;
   endtask

   task automatic checkResp(input logic isRead, input logic [`ADDR_W-1:0] addr,
                            input logic [`DATA_W-1:0] expData, input logic expHit,
                            input logic hit, input logic [`DATA_W-1:0] rdData,
                            input int latency);
      if (hit !== expHit) begin
         reportError($sformatf("%s %h: respHit %b, expected %b",
                               isRead ? "read" : "write", addr, hit, expHit));
      end
      if (isRead && rdData !== expData) begin
         reportError($sformatf("read %h: data %h, expected %h", addr, rdData, expData));
      end
      if (expHit && latency != 2) begin
         reportError($sformatf("hit at %h answered after %0d cycles, expected 2",
                               addr, latency));
      end
   endtask

   initial begin
      stepT               s;
      logic               modelHit;
      logic               expHit;
      logic               gotHit;
      logic [`DATA_W-1:0] gotData;
      logic [`DATA_W-1:0] expData;
      logic [`ADDR_W-1:0] addr;
      logic [31:0]        rnd;
      int                 latency;
      rstN        = 1'b0;
      reqValid    = 1'b0;
      reqRead     = 1'b0;
      reqAddr     = '0;
      reqWrData   = '0;
      errors      = 0;
      testErrors  = 0;
      testsRun    = 0;
      testsPassed = 0;
      timedOut    = 1'b0;
      refVictim   = 1'b0;
      rngState    = 32'd10;
      for (int i = 0; i < WORDS; i++) begin
         refMem[i] = '0;
      end
      for (int i = 0; i < SETS; i++) begin
         refValid[0][i] = 1'b0;
         refValid[1][i] = 1'b0;
      end
      // cold read misses with zero and the repeat hits
      addStep(1, 1'b1, 5'd1, 8'd5, 2'd0, 16'h0000, 1'b0);
      addStep(1, 1'b1, 5'd1, 8'd5, 2'd0, 16'h0000, 1'b1);
      addStep(2, 1'b0, 5'd2, 8'd6, 2'd1, 16'h1234, 1'b0);   // write-allocate
      addStep(2, 1'b1, 5'd2, 8'd6, 2'd1, 16'h1234, 1'b1);
      // tags 3 and 4 share set 9 and both end up dirty
      addStep(3, 1'b0, 5'd3, 8'd9, 2'd2, 16'hA5A5, 1'b0);
      addStep(3, 1'b0, 5'd4, 8'd9, 2'd3, 16'h5A5A, 1'b0);
      addStep(3, 1'b1, 5'd3, 8'd9, 2'd2, 16'hA5A5, 1'b1);
      addStep(3, 1'b1, 5'd4, 8'd9, 2'd3, 16'h5A5A, 1'b1);
      // victim bit is 1 on the 9th request so tag 5 evicts way 1
      addStep(4, 1'b1, 5'd5, 8'd9, 2'd0, 16'h0000, 1'b0);
      addStep(4, 1'b1, 5'd4, 8'd9, 2'd3, 16'h5A5A, 1'b0);   // comes back from memory
      addStep(4, 1'b1, 5'd3, 8'd9, 2'd2, 16'hA5A5, 1'b0);
      addStep(4, 1'b1, 5'd4, 8'd9, 2'd3, 16'h5A5A, 1'b1);
      addStep(4, 1'b1, 5'd3, 8'd9, 2'd1, 16'h0000, 1'b1);
      addStep(5, 1'b0, 5'd4, 8'd9, 2'd1, 16'hBEEF, 1'b1);   // write hit
      addStep(5, 1'b1, 5'd4, 8'd9, 2'd1, 16'hBEEF, 1'b1);
      addStep(5, 1'b1, 5'd7, 8'd20, 2'd3, 16'h0000, 1'b0);
      repeat (3) @(posedge clk);
      @(negedge clk);
      rstN = 1'b1;
      @(negedge clk);
      if (reqReady !== 1'b1 || respValid !== 1'b0 || DUT.memCmdValid !== 1'b0) begin
         reportError($sformatf("after reset reqReady %b respValid %b memCmdValid %b",
                               reqReady, respValid, DUT.memCmdValid));
      end
      for (int k = 0; k < steps.size() && !timedOut; k++) begin
         s        = steps[k];
         modelHit = modelAccess(s.addr);
         if (modelHit !== s.expHit) begin
            $display("table step %0d: hit model and table disagree", k);
            errors++;
            testErrors++;
         end
         doRequest(s.isRead, s.addr, s.data, gotHit, gotData, latency);
         if (!timedOut) begin
            checkResp(s.isRead, s.addr, s.data, s.expHit, gotHit, gotData, latency);
            if (!s.isRead) begin
               refMem[s.addr[`ADDR_W-1:1]] = s.data;
            end
            if (k == steps.size() - 1 || steps[k+1].testId != s.testId) begin
               finishTest(s.testId);
            end
         end
      end
      // four sets with four tags each give both hits and evictions
      for (int n = 0; n < N_RAND && !timedOut; n++) begin
         rngState = xorshift(rngState);
         rnd      = rngState;
         addr     = makeAddr({3'b010, rnd[3:2]}, 8'd40 + {6'd0, rnd[1:0]}, rnd[6:5]);
         expHit   = modelAccess(addr);
         expData  = refMem[addr[`ADDR_W-1:1]];
         doRequest(rnd[8], addr, rnd[31:16], gotHit, gotData, latency);
         if (!timedOut) begin
            checkResp(rnd[8], addr, expData, expHit, gotHit, gotData, latency);
            if (!rnd[8]) begin
               refMem[addr[`ADDR_W-1:1]] = rnd[31:16];
            end
         end
      end
      if (!timedOut) begin
         finishTest(6);
      end
      $display("tests run %0d, passed %0d, errors %0d", testsRun, testsPassed, errors);
      if (errors == 0 && !timedOut) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

// ==== sources.f ====
+incdir+include
logic/memSysPkg.sv
logic/cacheWay.sv
logic/mainMemory.sv
logic/cacheController.sv
logic/memSystem.sv
verif/memSystemTb.sv

// ==== Makefile ====
# Verilator build for the two-way cache and its testbench
# make lint, make sim, make clean

SIM_LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f sources.f --top-module memSystemTb

sim:
	verilator --binary --timing --assert -f sources.f --top-module memSystemTb \
		-o memSystemSim
	./obj_dir/memSystemSim | tee $(SIM_LOG)
	grep -q "TB PASSED" $(SIM_LOG)

clean:
	rm -rf obj_dir $(SIM_LOG)
